/* vlog.f */
+incdir+logic
logic/replyPkg.sv
logic/frameCapture.sv
logic/replyTransmitter.sv
logic/frameResponder.sv
dv/frameResponder_props.sv
dv/frameResponder_tb.sv

/* run.sh */
#!/bin/sh
# build and run the frame responder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module frameResponder_tb -o simv \
  && ./obj_dir/simv +verilator+error+limit+100 | tee /dev/stderr | grep -qx "TEST PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* dv/frameResponder_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reply_params.svh"

module frameResponder_tb;

  localparam int NumFrames     = `REPLY_LIMIT + 2;
  localparam int TimeoutCycles = NumFrames * 40 + 100;
  localparam int QuietCycles   = 20;  // watch time after each frame past the limit

  logic           clk;
  logic           reset;
  logic           inValid;
  replyPkg::wordT inData;
  logic           inLast;
  replyPkg::wordT hostLoad;
  logic           outValid;
  replyPkg::wordT outData;
  logic           outLast;
  logic           outReady;

  int             seed = 32'h58f4;
  int             readySeed;         // own stream for the sink, drawn from seed
  replyPkg::wordT expQ [$];          // expected reply words, in order
  int             beatCount = 0;
  int             repliesSeen = 0;

  frameResponder u_frameResponder (
    .clk      (clk),
    .reset    (reset),
    .inValid  (inValid),
    .inData   (inData),
    .inLast   (inLast),
    .hostLoad (hostLoad),
    .outValid (outValid),
    .outData  (outData),
    .outLast  (outLast),
    .outReady (outReady)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic reportMismatch(input string what, input replyPkg::wordT got,
                                input replyPkg::wordT exp);
    $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic reportFailure(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  // one frame of random words, expected reply queued after the twelfth
  task automatic sendFrame(input int len, input logic expectReply);
    replyPkg::wordT words [`FRAME_WORDS];
    replyPkg::wordT load;
    logic [95:0]    countSpan;  // words 8 to 10, count starts at bit 16
    logic [63:0]    instCount;
    int i;
    load     = $random(seed);
    hostLoad = load;  // held through the reply
    for (i = 0; i < len; i++) begin
      inValid = 1'b1;
      inData  = $random(seed);
      inLast  = (i == len - 1);
      if (i < `FRAME_WORDS) words[i] = inData;
      if (expectReply && i == `FRAME_WORDS - 1) begin
        for (int h = 0; h < `HEADER_WORDS; h++) expQ.push_back(words[h]);
        countSpan = {words[`COUNT_WORD + 2], words[`COUNT_WORD + 1], words[`COUNT_WORD]};
        instCount = countSpan[16 +: 64];
        expQ.push_back(instCount[31:0]);
        expQ.push_back(instCount[63:32]);
        expQ.push_back(load);
      end
      @(negedge clk);
    end
    inValid = 1'b0;
    inLast  = 1'b0;
  endtask

  ////////////////////////////////
  // sink
  ////////////////////////////////

  initial begin
    outReady = 1'b0;
    forever begin
      @(negedge clk);
      outReady = ($random(readySeed) & 3) != 0;  // ready three cycles in four
    end
  end

  // sample mid-cycle, the transfer happens on the next rising edge
  initial begin : monitor
    replyPkg::wordT expWord;
    forever begin
      @(negedge clk);
      #1;
      assert (u_frameResponder.u_frameResponderProps.failCount == 0)
        else reportFailure("a stream protocol assertion fired");
      if (outValid) begin
        assert (repliesSeen < `REPLY_LIMIT)
          else reportFailure("outValid rose after the reply limit");
      end
      if (outValid && outReady) begin
        assert (expQ.size() > 0) else reportFailure("reply word sent with no frame pending");
        expWord = expQ.pop_front();
        assert (outData == expWord) else reportMismatch("outData", outData, expWord);
        assert (outLast == (beatCount == `REPLY_WORDS - 1))
          else reportMismatch("outLast", replyPkg::wordT'(outLast),
                              replyPkg::wordT'(beatCount == `REPLY_WORDS - 1));
        if (outLast) begin
          repliesSeen++;
          beatCount = 0;
        end else begin
          beatCount++;
        end
      end
    end
  end

  ////////////////////////////////
  // main sequence
  ////////////////////////////////

  initial begin : stimulus
    int len;
    readySeed = $random(seed);
    reset     = 1'b1;
    inValid   = 1'b0;
    inData    = '0;
    inLast    = 1'b0;
    hostLoad  = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    for (int f = 0; f < NumFrames; f++) begin
      len = 12 + ($unsigned($random(seed)) % 4);
      sendFrame(len, f < `REPLY_LIMIT);
      if (f < `REPLY_LIMIT) begin
        while (repliesSeen < f + 1) @(negedge clk);  // outLast handshake
      end else begin
        repeat (QuietCycles) @(negedge clk);  // engine should stay silent
      end
    end
    assert (expQ.size() == 0) else reportFailure("expected reply words never sent");
    if (u_frameResponder.u_frameResponderProps.failCount != 0) begin
      $display("stream protocol assertions fired during the run");
      $display("TEST FAIL");
      $fatal(1);
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

  initial begin : watchdog
    repeat (TimeoutCycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("TEST FAIL");
    $fatal(1);
  end

endmodule

`default_nettype wire

/* dv/frameResponder_props.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reply_params.svh"

module frameResponder_props (
  input logic               clk,
  input logic               reset,
  input logic               outValid,
  input logic               outReady,
  input logic               outLast,
  input replyPkg::wordT     outData,
  input replyPkg::replyIdxT wordIdx
);

  int unsigned failCount = 0;  // read by the testbench

  ////////////////////////////////
  // output stream protocol
  ////////////////////////////////

  quietAfterReset: assert property (@(posedge clk)
    reset |=> !outValid && !outLast)
    else begin
      failCount = failCount + 1;
      $error("outValid or outLast high right after reset");
    end

  // stalled word must not move
  holdOnStall: assert property (@(posedge clk) disable iff (reset)
    outValid && !outReady |=> outValid && $stable(outData) && $stable(outLast))
    else begin
      failCount = failCount + 1;
      $error("output word changed or dropped while stalled");
    end

  startAtZero: assert property (@(posedge clk) disable iff (reset)
    $rose(outValid) |-> wordIdx == '0)
    else begin
      failCount = failCount + 1;
      $error("reply did not start at word 0");
    end

  gapAfterReply: assert property (@(posedge clk) disable iff (reset)
    outValid && outReady && outLast |=> !outValid)  // finished state
    else begin
      failCount = failCount + 1;
      $error("outValid high in the cycle after a reply");
    end

endmodule

bind frameResponder frameResponder_props u_frameResponderProps (
  .clk      (clk),
  .reset    (reset),
  .outValid (outValid),
  .outReady (outReady),
  .outLast  (outLast),
  .outData  (outData),
  .wordIdx  (wordIdx)
);

`default_nettype wire

/* logic/frameResponder.sv */
`timescale 1ns/100ps
`default_nettype none

module frameResponder (
  input  logic           clk,
  input  logic           reset,
  // frame stream in, never stalled
  input  logic           inValid,
  input  replyPkg::wordT inData,
  input  logic           inLast,
  // host load estimate
  input  replyPkg::wordT hostLoad,
  // reply stream out
  output logic           outValid,
  output replyPkg::wordT outData,
  output logic           outLast,
  input  logic           outReady
);

  logic               frameReady;  // twelve words captured
  replyPkg::replyIdxT wordIdx;
  replyPkg::wordT     replyWord;

  //////////////////////////////
  // receive side
  //////////////////////////////

  frameCapture u_frameCapture (
    .clk        (clk),
    .reset      (reset),
    .inValid    (inValid),
    .inData     (inData),
    .inLast     (inLast),
    .wordIdx    (wordIdx),
    .frameReady (frameReady),
    .replyWord  (replyWord)
  );

  //////////////////////////////
  // transmit side
  //////////////////////////////

  replyTransmitter u_replyTransmitter (
    .clk        (clk),
    .reset      (reset),
    .frameReady (frameReady),
    .replyWord  (replyWord),
    .hostLoad   (hostLoad),
    .outReady   (outReady),
    .wordIdx    (wordIdx),
    .outValid   (outValid),
    .outLast    (outLast),
    .outData    (outData)
  );

endmodule

`default_nettype wire

/* logic/replyTransmitter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reply_params.svh"

module replyTransmitter (
  input  logic               clk,
  input  logic               reset,
  input  logic               frameReady,
  input  replyPkg::wordT     replyWord,
  input  replyPkg::wordT     hostLoad,
  input  logic               outReady,
  output replyPkg::replyIdxT wordIdx,
  output logic               outValid,
  output logic               outLast,
  output replyPkg::wordT     outData
);

  localparam int CountW = $clog2(`REPLY_LIMIT + 1);

  replyPkg::transStateT state, nextState;
  replyPkg::wordT       loadReg;
  logic [CountW-1:0]    replyCount;

  logic limitHit;
  logic startReply;
  logic handshake;
  logic lastWord;

  assign limitHit   = replyCount == CountW'(`REPLY_LIMIT);
  assign startReply = (state == replyPkg::txReady) & frameReady & ~limitHit;
  assign handshake  = outValid & outReady;
  assign lastWord   = wordIdx == replyPkg::replyIdxT'(`REPLY_WORDS - 1);

  //////////////////////////////
  // transmit FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= replyPkg::txReady;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      replyPkg::txReady: begin
        if (startReply) begin
          nextState = outReady ? replyPkg::txSend : replyPkg::txWait;
        end
      end
      replyPkg::txWait: begin
        if (outReady) nextState = replyPkg::txSend;
      end
      replyPkg::txSend: begin
        if (handshake & lastWord) nextState = replyPkg::txFinished;
      end
      replyPkg::txFinished: begin
        nextState = replyPkg::txReady;
      end
      default: nextState = replyPkg::txReady;
    endcase
  end

  // word counter, moves only on a handshake so data holds under stall
  always_ff @(posedge clk) begin
    if (reset) begin
      wordIdx <= '0;
    end else if (state == replyPkg::txReady) begin
      wordIdx <= '0;
    end else if (handshake) begin
      if (lastWord) begin
        wordIdx <= '0;
      end else begin
        wordIdx <= wordIdx + 1'b1;
      end
    end
  end

  // host load, sampled once per frame
  always_ff @(posedge clk) begin
    if (startReply) loadReg <= hostLoad;
  end

  //////////////////////////////
  // reply limit
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      replyCount <= '0;
    end else if (state == replyPkg::txFinished) begin
      replyCount <= replyCount + 1'b1;  // stops at the limit, no new replies
    end
  end

  //////////////////////////////
  // output stream
  //////////////////////////////

  assign outValid = state == replyPkg::txSend;
  assign outLast  = outValid & lastWord;
  assign outData  = lastWord ? loadReg : replyWord;  // last word is the load

endmodule

`default_nettype wire

/* logic/frameCapture.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reply_params.svh"

module frameCapture (
  input  logic              clk,
  input  logic              reset,
  input  logic              inValid,
  input  replyPkg::wordT    inData,
  input  logic              inLast,
  input  replyPkg::replyIdxT wordIdx,
  output logic              frameReady,
  output replyPkg::wordT    replyWord
);

  replyPkg::captureStateT state, nextState;
  replyPkg::frameIdxT     wrIdx;
  replyPkg::wordT         frameBuf [`FRAME_WORDS];

  logic take;        // word written into the buffer this cycle
  logic wordTwelve;  // the last word we keep

  //////////////////////////////
  // receive FSM
  //////////////////////////////

  assign take       = inValid & (state != replyPkg::capDrain);
  assign wordTwelve = take & (wrIdx == replyPkg::frameIdxT'(`FRAME_WORDS - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= replyPkg::capIdle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      replyPkg::capDrain: begin
        if (inValid & inLast) nextState = replyPkg::capDone;
      end
      default: begin
        // idle, capture and done all accept the next word
        if (take) begin
          if (wordTwelve) begin
            nextState = inLast ? replyPkg::capDone : replyPkg::capDrain;
          end else if (inLast) begin
            nextState = replyPkg::capIdle;  // runt frame, dropped
          end else begin
            nextState = replyPkg::capCapture;
          end
        end else if (state == replyPkg::capDone) begin
          nextState = replyPkg::capIdle;
        end
      end
    endcase
  end

  // write pointer, back to zero at the end of every frame
  always_ff @(posedge clk) begin
    if (reset) begin
      wrIdx <= '0;
    end else if (take) begin
      if (wordTwelve | inLast) begin
        wrIdx <= '0;
      end else begin
        wrIdx <= wrIdx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      frameReady <= 1'b0;
    end else begin
      frameReady <= wordTwelve;  // one cycle after the twelfth word
    end
  end

  always_ff @(posedge clk) begin
    if (take) frameBuf[wrIdx] <= inData;
  end

  //////////////////////////////
  // reply word select
  //////////////////////////////

  // count field sits 16 bits into word 8, realign into two words
  always_comb begin
    replyWord = '0;  // index 6 comes from the transmitter
    if (wordIdx < replyPkg::replyIdxT'(`HEADER_WORDS)) begin
      replyWord = frameBuf[replyPkg::frameIdxT'(wordIdx)];
    end else if (wordIdx == replyPkg::replyIdxT'(`HEADER_WORDS)) begin
      replyWord = {frameBuf[`COUNT_WORD + 1][15:0], frameBuf[`COUNT_WORD][31:16]};
    end else if (wordIdx == replyPkg::replyIdxT'(`HEADER_WORDS + 1)) begin
      replyWord = {frameBuf[`COUNT_WORD + 2][15:0], frameBuf[`COUNT_WORD + 1][31:16]};
    end
  end

endmodule

`default_nettype wire

/* logic/replyPkg.sv */
`default_nettype none

package replyPkg;

  ///////////////////////////////
  // stream and index types
  ///////////////////////////////

  typedef logic [31:0] wordT;      // one stream word
  typedef logic [3:0]  frameIdxT;  // captured word 0..11
  typedef logic [2:0]  replyIdxT;  // reply word 0..6

  ///////////////////////////////
  // state machines
  ///////////////////////////////

  // receive side
  typedef enum logic [1:0] {
    capIdle,
    capCapture,
    capDrain,   // twelve words kept, skip to inLast
    capDone
  } captureStateT;

  // transmit side
  typedef enum logic [1:0] {
    txReady,
    txWait,     // frame ready but sink not ready yet
    txSend,
    txFinished
  } transStateT;

endpackage

`default_nettype wire

/* logic/reply_params.svh */
`ifndef REPLY_PARAMS_SVH
`define REPLY_PARAMS_SVH

// words kept from the front of each frame
`define FRAME_WORDS 12

// words in one reply frame
`define REPLY_WORDS 7

// header words copied through unchanged
`define HEADER_WORDS 4

// first captured word holding the retired-instruction count
`define COUNT_WORD 8

// replies sent after reset before the engine goes quiet
`define REPLY_LIMIT 8

`endif
